// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module boot_tb -o boot_tb
	./obj_dir/boot_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+source
source/boot_pkg.sv
source/boot_if.sv
source/uart_rx.sv
source/word_packer.sv
source/mem_arbiter.sv
source/word_mem.sv
source/boot_top.sv
testbench/boot_tb.sv

// ==== source/boot_if.sv ====
`default_nettype none
`include "boot_macros.svh"

////////////////////////////////////////////////////////////////////////////
// Packer to write queue, credit based
////////////////////////////////////////////////////////////////////////////

interface wr_credit_if;
    logic               push;
    logic [`ADDR_W-1:0] addr;
    logic [31:0]        data;
    // One pulse per queued write issued to memory
    logic               credit_return;

    modport packer (
        output push,
        output addr,
        output data,
        input  credit_return
    );

    modport arbiter (
        input  push,
        input  addr,
        input  data,
        output credit_return
    );
endinterface

////////////////////////////////////////////////////////////////////////////
// Arbiter to word memory
////////////////////////////////////////////////////////////////////////////

interface mem_access_if
    import boot_pkg::*;
();
    logic               req;
    mem_op_e            op;
    logic [`ADDR_W-1:0] addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;
    logic               rd_valid;

    modport master (output req, output op, output addr, output wdata,
                    input rdata, input rd_valid);

    modport slave (input req, input op, input addr, input wdata,
                   output rdata, output rd_valid);
endinterface

`default_nettype wire

// ==== source/boot_macros.svh ====
`ifndef BOOT_MACROS_SVH
`define BOOT_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial timing
////////////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit
`define BIT_CYCLES 16
// Idle bit times before the loader finishes
`define IDLE_BITS 12

////////////////////////////////////////////////////////////////////////////
// Memory and write queue
////////////////////////////////////////////////////////////////////////////

`define MEM_WORDS 16
`define ADDR_W 4
`define WQ_DEPTH 2

`endif

// ==== source/boot_pkg.sv ====
`default_nettype none

package boot_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Receiver FSM
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Memory access
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // Last winner of the arbiter
    typedef enum logic {
        GNT_WRITE,
        GNT_READ
    } grant_e;

endpackage

`default_nettype wire

// ==== source/boot_top.sv ====
`default_nettype none
`include "boot_macros.svh"

module boot_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    input  logic               rd_req,
    input  logic [`ADDR_W-1:0] rd_addr,
    output logic [31:0]        rd_data,
    output logic               rd_valid,
    output logic               done,
    output logic               frame_error
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       idle_timeout;

    wr_credit_if  wr_bus ();
    mem_access_if mem_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Serial receive and packing
    ////////////////////////////////////////////////////////////////////////////

    uart_rx u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .idle_timeout (idle_timeout),
        .frame_error  (frame_error)
    );

    word_packer u_packer (
        .clk          (clk),
        .rst          (rst),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .idle_timeout (idle_timeout),
        .wr           (wr_bus.packer),
        .done         (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Shared memory
    ////////////////////////////////////////////////////////////////////////////

    mem_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr_bus.arbiter),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .mem      (mem_bus.master)
    );

    word_mem u_mem (
        .clk (clk),
        .mem (mem_bus.slave)
    );

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none
`include "boot_macros.svh"

module mem_arbiter
    import boot_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    wr_credit_if.arbiter       wr,
    input  logic               rd_req,
    input  logic [`ADDR_W-1:0] rd_addr,
    output logic               rd_valid,
    output logic [31:0]        rd_data,
    mem_access_if.master       mem
);

    localparam int QP_W = (`WQ_DEPTH > 1) ? $clog2(`WQ_DEPTH) : 1;
    localparam int QC_W = $clog2(`WQ_DEPTH + 1);
    localparam logic [QP_W-1:0] QP_LAST = QP_W'(`WQ_DEPTH - 1);
    localparam logic [QC_W-1:0] QC_FULL = QC_W'(`WQ_DEPTH);

    logic [`ADDR_W-1:0] q_addr [`WQ_DEPTH];
    logic [31:0]        q_data [`WQ_DEPTH];
    logic [QP_W-1:0]    wr_ptr;
    logic [QP_W-1:0]    rd_ptr;
    logic [QC_W-1:0]    q_count;
    grant_e             last_gnt;
    logic               rd_busy;
    logic               wr_pend;
    logic               rd_pend;
    logic               gnt_wr;
    logic               gnt_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Round robin, one access per cycle
    ////////////////////////////////////////////////////////////////////////////

    assign wr_pend = (q_count != '0);
    assign rd_pend = rd_req && !rd_busy;
    assign gnt_wr  = wr_pend && (!rd_pend || last_gnt == GNT_READ);
    assign gnt_rd  = rd_pend && !gnt_wr;

    assign mem.req   = gnt_wr || gnt_rd;
    assign mem.op    = gnt_wr ? MEM_WRITE : MEM_READ;
    assign mem.addr  = gnt_wr ? q_addr[rd_ptr] : rd_addr;
    assign mem.wdata = q_data[rd_ptr];

    assign wr.credit_return = gnt_wr;

    always_ff @(posedge clk) begin
        if (wr.push) begin
            q_addr[wr_ptr] <= wr.addr;
            q_data[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_count  <= '0;
            last_gnt <= GNT_READ;
            rd_busy  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (wr.push) wr_ptr <= (wr_ptr == QP_LAST) ? '0 : wr_ptr + 1'b1;
            if (gnt_wr)  rd_ptr <= (rd_ptr == QP_LAST) ? '0 : rd_ptr + 1'b1;
            case ({wr.push, gnt_wr})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            if (gnt_wr)      last_gnt <= GNT_WRITE;
            else if (gnt_rd) last_gnt <= GNT_READ;
            // Held until the host drops its request
            if (gnt_rd)       rd_busy <= 1'b1;
            else if (!rd_req) rd_busy <= 1'b0;
            rd_valid <= mem.rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.rd_valid) rd_data <= mem.rdata;
    end

    // Packer credits keep the queue from overflowing
    assert property (@(posedge clk) disable iff (rst) wr.push |-> q_count != QC_FULL);

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none
`include "boot_macros.svh"

module uart_rx
    import boot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       idle_timeout,
    output logic       frame_error
);

    localparam int CNT_W  = $clog2(`BIT_CYCLES);
    localparam int IDLE_W = $clog2(`IDLE_BITS + 1);
    localparam logic [CNT_W-1:0]  CNT_LAST  = CNT_W'(`BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0]  CNT_HALF  = CNT_W'(`BIT_CYCLES / 2 - 1);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`IDLE_BITS - 1);

    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic              fall;
    rx_state_e         state;
    logic [CNT_W-1:0]  cyc_cnt;
    logic [2:0]        bit_idx;
    logic              armed;
    logic              fired;
    logic [CNT_W-1:0]  idle_cyc;
    logic [IDLE_W-1:0] idle_bits;

    // Two flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev & ~rx_sync;

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM, samples at mid bit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            cyc_cnt     <= '0;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                IDLE: begin
                    cyc_cnt <= '0;
                    if (fall) state <= START;
                end
                START: begin
                    if (cyc_cnt == CNT_HALF) begin
                        cyc_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch, not a real start bit
                        state   <= rx_sync ? IDLE : DATA;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (cyc_cnt == CNT_LAST) begin
                        cyc_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (cyc_cnt == CNT_LAST) begin
                        cyc_cnt <= '0;
                        state   <= IDLE;
                        if (rx_sync) byte_valid  <= 1'b1;
                        else         frame_error <= 1'b1;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == DATA && cyc_cnt == CNT_LAST) byte_data <= {rx_sync, byte_data[7:1]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Idle timer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            armed        <= 1'b0;
            fired        <= 1'b0;
            idle_cyc     <= '0;
            idle_bits    <= '0;
            idle_timeout <= 1'b0;
        end else begin
            idle_timeout <= 1'b0;
            if (byte_valid) armed <= 1'b1;
            if (state != IDLE) begin
                idle_cyc  <= '0;
                idle_bits <= '0;
                fired     <= 1'b0;
            end else if (armed && !fired) begin
                if (idle_cyc == CNT_LAST) begin
                    idle_cyc <= '0;
                    if (idle_bits == IDLE_LAST) begin
                        idle_timeout <= 1'b1;
                        fired        <= 1'b1;
                        idle_bits    <= '0;
                    end else begin
                        idle_bits <= idle_bits + 1'b1;
                    end
                end else begin
                    idle_cyc <= idle_cyc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/word_mem.sv ====
`default_nettype none
`include "boot_macros.svh"

module word_mem
    import boot_pkg::*;
(
    input logic         clk,
    mem_access_if.slave mem
);

    logic [31:0] store [`MEM_WORDS];
    logic        rd_hit;

    assign rd_hit = mem.req && (mem.op == MEM_READ);

    always_ff @(posedge clk) begin
        if (mem.req && mem.op == MEM_WRITE) store[mem.addr] <= mem.wdata;
    end

    // Registered read, valid one cycle after the request
    always_ff @(posedge clk) begin
        mem.rd_valid <= rd_hit;
        if (rd_hit) mem.rdata <= store[mem.addr];
    end

endmodule

`default_nettype wire

// ==== source/word_packer.sv ====
`default_nettype none
`include "boot_macros.svh"

module word_packer (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       idle_timeout,
    wr_credit_if.packer wr,
    output logic       done
);

    localparam int CR_W = $clog2(`WQ_DEPTH + 1);
    localparam int AW1  = `ADDR_W + 1;
    localparam logic [CR_W-1:0] CR_FULL  = CR_W'(`WQ_DEPTH);
    localparam logic [AW1-1:0]  ADDR_END = AW1'(`MEM_WORDS);

    logic [31:0]     acc;
    logic [1:0]      byte_cnt;
    logic [31:0]     out_word;
    logic            out_valid;
    logic [AW1-1:0]  addr;
    logic [CR_W-1:0] credits;
    logic            flushed;
    logic            full;
    logic            accept;
    logic            word_done;
    logic            take_timeout;
    logic            flush_now;
    logic            push;

    assign full         = (addr == ADDR_END);
    assign accept       = byte_valid && !done && !flushed && !full;
    assign word_done    = accept && (byte_cnt == 2'd3);
    assign take_timeout = idle_timeout && !done && !flushed;
    assign flush_now    = take_timeout && (byte_cnt != 2'd0);
    assign push         = out_valid && (credits != '0);

    assign wr.push = push;
    assign wr.addr = addr[`ADDR_W-1:0];
    assign wr.data = out_word;

    ////////////////////////////////////////////////////////////////////////////
    // Byte assembly, little endian
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            byte_cnt  <= '0;
            out_valid <= 1'b0;
            flushed   <= 1'b0;
        end else begin
            if (push) out_valid <= 1'b0;
            if (accept) begin
                if (word_done) begin
                    out_valid <= 1'b1;
                    acc       <= '0;
                end else begin
                    acc[8*byte_cnt +: 8] <= byte_data;
                end
                byte_cnt <= byte_cnt + 1'b1;
            end else if (take_timeout) begin
                flushed <= 1'b1;
                // Upper bytes already zero
                if (flush_now) begin
                    out_valid <= 1'b1;
                    acc       <= '0;
                    byte_cnt  <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_done)      out_word <= {byte_data, acc[23:0]};
        else if (flush_now) out_word <= acc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address, credits, done
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            addr    <= '0;
            credits <= CR_FULL;
            done    <= 1'b0;
        end else begin
            if (push) addr <= addr + 1'b1;
            case ({push, wr.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if ((full || flushed) && !out_valid && credits == CR_FULL) done <= 1'b1;
        end
    end

    // Arbiter must never return more credits than were spent
    assert property (@(posedge clk) disable iff (rst) credits <= CR_FULL);

    // A finished word never lands on one still waiting for a credit
    assert property (@(posedge clk) disable iff (rst) word_done |-> !out_valid || push);

endmodule

`default_nettype wire

// ==== testbench/boot_tb.sv ====
`default_nettype none
`include "boot_macros.svh"

module boot_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_T      = `BIT_CYCLES;
    localparam int READ_LIMIT = 64;

    logic               clk = 1'b0;
    logic               rst;
    logic               rx;
    logic               rd_req;
    logic [`ADDR_W-1:0] rd_addr;
    logic [31:0]        rd_data;
    logic               rd_valid;
    logic               done;
    logic               frame_error;

    int          errors      = 0;
    int          timeouts    = 0;
    int          checks      = 0;
    logic        loading     = 1'b0;
    logic        reader_busy = 1'b0;
    logic        read_active = 1'b0;
    int          known_words = 0;
    // Reference model of the packer, built from the byte stream
    logic [31:0] exp_mem [`MEM_WORDS];
    int          model_addr;
    int          model_cnt;
    logic [31:0] model_word;
    logic        model_armed;
    logic        model_done;

    always #4 clk = ~clk;

    boot_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .done        (done),
        .frame_error (frame_error)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        timeouts++;
        finish_run();
    endtask

    task automatic check_reset_outputs();
        if (done !== 1'b0) begin
            $display("FAILED done: got %h expected 0", done);
            errors++;
        end
        if (rd_valid !== 1'b0) begin
            $display("FAILED rd_valid: got %h expected 0", rd_valid);
            errors++;
        end
        if (frame_error !== 1'b0) begin
            $display("FAILED frame_error: got %h expected 0", frame_error);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst         = 1'b1;
        rx          = 1'b1;
        rd_req      = 1'b0;
        loading     = 1'b0;
        known_words = 0;
        model_addr  = 0;
        model_cnt   = 0;
        model_word  = '0;
        model_armed = 1'b0;
        model_done  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_outputs();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial line
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_bit(input logic v);
        rx = v;
        repeat (BIT_T) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic stop);
        loading = 1'b1;
        drive_bit(1'b0);
        // Words finished before this byte are in memory by now
        known_words = model_addr;
        for (int i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(stop);
        // Line back high so the next start bit has an edge
        if (!stop) drive_bit(1'b1);
        if (stop && !model_done) begin
            model_armed = 1'b1;
            model_word[8*model_cnt +: 8] = b;
            model_cnt++;
            if (model_cnt == 4) begin
                exp_mem[model_addr] = model_word;
                model_addr++;
                model_cnt  = 0;
                model_word = '0;
                if (model_addr == `MEM_WORDS) model_done = 1'b1;
            end
        end
    endtask

    task automatic idle_gap(input int n);
        repeat (n) drive_bit(1'b1);
        if (n > `IDLE_BITS && model_armed && !model_done) begin
            // Partial word goes out zero padded
            if (model_cnt != 0) begin
                exp_mem[model_addr] = model_word;
                model_addr++;
            end
            model_done = 1'b1;
        end
        known_words = model_addr;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host port
    ////////////////////////////////////////////////////////////////////////////

    task automatic host_read(input logic [`ADDR_W-1:0] a, output logic [31:0] data);
        int waited;
        waited      = 0;
        data        = 'x;
        rd_addr     = a;
        rd_req      = 1'b1;
        read_active = 1'b1;
        while (!rd_valid && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            report_timeout("host read got no rd_valid");
        end else begin
            if (waited < 2) begin
                $display("Error: rd_valid came %0d cycle after the request", waited);
                errors++;
            end
            data   = rd_data;
            rd_req = 1'b0;
            @(negedge clk);
            read_active = 1'b0;
        end
    endtask

    task automatic check_word(input int a, input logic [31:0] expected);
        logic [31:0] data;
        host_read(a[`ADDR_W-1:0], data);
        checks++;
        if (data !== expected) begin
            $display("FAILED rd_data at %h: got %h expected %h", a, data, expected);
            errors++;
        end
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (!done && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) report_timeout("done did not rise");
    endtask

    task automatic wait_reader();
        int waited;
        waited = 0;
        while (reader_busy && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reader_busy) report_timeout("contention reader did not finish");
    endtask

    task automatic finish_load(input logic exp_fe, input int limit);
        wait_done(limit);
        loading = 1'b0;
        @(negedge clk);
        wait_reader();
        known_words = model_addr;
        checks++;
        if (frame_error !== exp_fe) begin
            $display("FAILED frame_error: got %h expected %h", frame_error, exp_fe);
            errors++;
        end
    endtask

    // Fills every word, done must follow without an idle gap
    task automatic fill_run(input logic [7:0] base);
        logic [31:0] w;
        for (int i = 0; i < 4 * `MEM_WORDS; i++) send_byte(base + 8'(i), 1'b1);
        finish_load(1'b0, 3 * BIT_T);
        for (int a = 0; a < `MEM_WORDS; a++) begin
            for (int k = 0; k < 4; k++) w[8*k +: 8] = base + 8'(4 * a + k);
            check_word(a, w);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && rd_valid && !read_active) begin
            $display("Error: rd_valid pulsed with no host read pending");
            errors++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random host reads during loading
    ////////////////////////////////////////////////////////////////////////////

    initial begin : contention_reader
        logic [31:0] seed;
        logic [31:0] data;
        int          gap;
        int          a;
        seed = 32'h24cb65d6;
        forever begin
            seed = next_random(seed);
            gap  = 2 + int'(seed[7:4]);
            repeat (gap) @(negedge clk);
            if (loading && known_words > 0) begin
                reader_busy = 1'b1;
                seed = next_random(seed);
                a    = int'(seed[15:8]) % known_words;
                host_read(a[`ADDR_W-1:0], data);
                checks++;
                if (data !== exp_mem[a]) begin
                    $display("FAILED rd_data at %h: got %h expected %h", a, data, exp_mem[a]);
                    errors++;
                end
                reader_busy = 1'b0;
            end
        end
    end

    initial begin : run_file
        int               fd;
        int               code;
        int               num;
        logic [7:0]       kind;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [8*120-1:0] rest;
        rst     = 1'b1;
        rx      = 1'b1;
        rd_req  = 1'b0;
        rd_addr = '0;
        fd = $fopen("testbench/boot_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/boot_testdata.txt");
            errors++;
            finish_run();
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1) begin
                    case (kind)
                        "#": code = $fgets(rest, fd);
                        "R": apply_reset();
                        "B": begin
                            code = $fscanf(fd, "%h %h", v1, v2);
                            send_byte(v1[7:0], v2[0]);
                        end
                        "I": begin
                            code = $fscanf(fd, "%d", num);
                            idle_gap(num);
                        end
                        "W": begin
                            code = $fscanf(fd, "%h", v1);
                            finish_load(v1[0], 40 * BIT_T);
                        end
                        "C": begin
                            code = $fscanf(fd, "%h %h", v1, v2);
                            check_word(int'(v1), v2);
                        end
                        "F": begin
                            code = $fscanf(fd, "%h", v1);
                            fill_run(v1[7:0]);
                        end
                        default: begin
                            $display("Unknown line kind %s in test data", kind);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            finish_run();
        end
    end

endmodule

`default_nettype wire

// ==== testbench/boot_testdata.txt ====
# B byte stop_bit | I idle_bit_times | W expected_frame_error after done
# C word_address expected_word | R reset | F base byte of a full memory run
R
B 11 1
B 22 1
B 33 1
B 44 1
B a5 0
B 55 1
B 66 1
B 77 1
B 88 1
B 99 1
B c3 1
I 16
W 1
C 0 44332211
C 1 88776655
C 2 0000c399
R
F 3c
